// ==== common/opn_pkg.sv ====
// OPN control section shared constants
// Register map of the timer block, field widths, timebase ratios
// and the bus busy window length
package opn_pkg;

    // Timebase
    localparam int PRESCALE      = 6;   // Clocks per internal clock enable
    localparam int SLOTS         = 24;  // 6 channels x 4 operators
    localparam int SAMPLE_CYCLES = PRESCALE * SLOTS;
    localparam int PRE_W         = $clog2(PRESCALE);
    localparam int SLOT_W        = $clog2(SLOTS);

    // Timer widths
    localparam int TA_W   = 10;
    localparam int TB_W   = 8;
    localparam int TB_DIV = 16;         // Sample ticks per timer B count

    // Busy flag after each data write
    localparam int BUSY_CYCLES = 32;
    localparam int BUSY_W      = $clog2(BUSY_CYCLES + 1);

    // Part 1 register addresses
    localparam logic [7:0] REG_TA_HI = 8'h24;   // Timer A bits 9..2
    localparam logic [7:0] REG_TA_LO = 8'h25;   // Timer A bits 1..0
    localparam logic [7:0] REG_TB    = 8'h26;
    localparam logic [7:0] REG_TCTL  = 8'h27;   // Timer control

    // Bit positions inside register 0x27
    localparam int CTL_LOAD_A = 0;
    localparam int CTL_LOAD_B = 1;
    localparam int CTL_EN_A   = 2;
    localparam int CTL_EN_B   = 3;
    localparam int CTL_RST_A  = 4;
    localparam int CTL_RST_B  = 5;

endpackage

// ==== hw/timers/opn_timer_cnt.sv ====
// Single up-counting timer
// Optional tick divider in front, holds value while not loading,
// counts divided ticks while loading, reloads and pulses overflow
// when the count passes all ones
`timescale 1ns/1ps

module opn_timer_cnt import opn_pkg::*; #(
    parameter int CNT_W    = TA_W,
    parameter int TICK_DIV = 1
) (
    input  logic             zero,
    input  logic             rst,
    input  logic             tick,
    input  logic             load,
    input  logic [CNT_W-1:0] value,
    output logic             overflow
);

    logic             cnt_tick;
    logic [CNT_W-1:0] cnt;

    generate
        if (TICK_DIV > 1) begin : gen_div
            localparam int DIV_W = $clog2(TICK_DIV);
            logic [DIV_W-1:0] div_cnt;
            logic             div_wrap;

            assign div_wrap = div_cnt == DIV_W'(TICK_DIV - 1);
            assign cnt_tick = tick && div_wrap;

            always_ff @(posedge zero) begin
                if (rst) begin
                    div_cnt <= '0;
                end else if (tick) begin
                    div_cnt <= div_wrap ? '0 : div_cnt + 1'b1;
                end
            end
        end else begin : gen_nodiv
            assign cnt_tick = tick;   // Every tick counts
        end
    endgenerate

    assign overflow = load && cnt_tick && (cnt == '1);

    always_ff @(posedge zero) begin
        if (rst) begin
            cnt <= '0;
        end else if (!load) begin
            cnt <= value;             // Track the register while stopped
        end else if (cnt_tick) begin
            cnt <= overflow ? value : cnt + 1'b1;
        end
    end

endmodule

// ==== hw/timers/opn_timers.sv ====
// Timer block
// Timer A counts every sample, timer B every TB_DIV samples.
// Overflows set the flags when enabled, clear strobes reset them,
// and irq_n is low while any flag is up
`timescale 1ns/1ps

module opn_timers import opn_pkg::*; (
    input  logic            zero,
    input  logic            rst,
    input  logic            sample_tick,
    input  logic [TA_W-1:0] value_a,
    input  logic [TB_W-1:0] value_b,
    input  logic            load_a,
    input  logic            load_b,
    input  logic            en_a,
    input  logic            en_b,
    input  logic            clr_a,
    input  logic            clr_b,
    output logic            flag_a,
    output logic            flag_b,
    output logic            irq_n
);

    logic ovf_a, ovf_b;
    logic flag_a_nx, flag_b_nx;

    opn_timer_cnt #(
        .CNT_W    ( TA_W ),
        .TICK_DIV ( 1    )
    ) u_timer_a (
        .zero     ( zero        ),
        .rst      ( rst         ),
        .tick     ( sample_tick ),
        .load     ( load_a      ),
        .value    ( value_a     ),
        .overflow ( ovf_a       )
    );

    opn_timer_cnt #(
        .CNT_W    ( TB_W   ),
        .TICK_DIV ( TB_DIV )
    ) u_timer_b (
        .zero     ( zero        ),
        .rst      ( rst         ),
        .tick     ( sample_tick ),
        .load     ( load_b      ),
        .value    ( value_b     ),
        .overflow ( ovf_b       )
    );

    // Clear beats a set in the same cycle
    assign flag_a_nx = clr_a ? 1'b0 : (flag_a || (ovf_a && en_a));
    assign flag_b_nx = clr_b ? 1'b0 : (flag_b || (ovf_b && en_b));

    always_ff @(posedge zero) begin
        if (rst) begin
            flag_a <= 1'b0;
            flag_b <= 1'b0;
            irq_n  <= 1'b1;
        end else begin
            flag_a <= flag_a_nx;
            flag_b <= flag_b_nx;
            irq_n  <= !(flag_a_nx || flag_b_nx);  // In step with the flags
        end
    end

endmodule

// ==== hw/regs/opn_regs.sv ====
// Bus register block
// Decodes CPU writes into the address latch and the timer registers
// 0x24..0x27, makes the flag clear strobes, times the busy window
// and builds the status byte
`timescale 1ns/1ps

module opn_regs import opn_pkg::*; (
    input  logic            zero,
    input  logic            rst,
    input  logic [7:0]      din,
    input  logic [1:0]      addr,
    input  logic            cs_n,
    input  logic            wr_n,
    input  logic            flag_a,
    input  logic            flag_b,
    output logic [TA_W-1:0] value_a,
    output logic [TB_W-1:0] value_b,
    output logic            load_a,
    output logic            load_b,
    output logic            en_a,
    output logic            en_b,
    output logic            clr_a,
    output logic            clr_b,
    output logic [7:0]      dout
);

    logic              write;
    logic              addr_wr;   // Address phase
    logic              data_wr;   // Data phase, either part
    logic              reg_we;    // Data phase to part 1
    logic [7:0]        reg_addr;
    logic [BUSY_W-1:0] busy_cnt;
    logic              busy;
    logic              ctl_wr;

    assign write   = !cs_n && !wr_n;
    assign addr_wr = write && !addr[0];
    assign data_wr = write && addr[0];
    assign reg_we  = data_wr && !addr[1];
    assign ctl_wr  = reg_we && (reg_addr == REG_TCTL);

    // Address latch, shared by both parts
    always_ff @(posedge zero) begin
        if (rst) begin
            reg_addr <= '0;
        end else if (addr_wr) begin
            reg_addr <= din;
        end
    end

    // Timer value registers
    always_ff @(posedge zero) begin
        if (rst) begin
            value_a <= '0;
            value_b <= '0;
        end else if (reg_we) begin
            case (reg_addr)
                REG_TA_HI: value_a[TA_W-1:2] <= din;
                REG_TA_LO: value_a[1:0]      <= din[1:0];
                REG_TB:    value_b           <= din;
                default: ;
            endcase
        end
    end

    // Load and enable bits of 0x27
    always_ff @(posedge zero) begin
        if (rst) begin
            load_a <= 1'b0;
            load_b <= 1'b0;
            en_a   <= 1'b0;
            en_b   <= 1'b0;
        end else if (ctl_wr) begin
            load_a <= din[CTL_LOAD_A];
            load_b <= din[CTL_LOAD_B];
            en_a   <= din[CTL_EN_A];
            en_b   <= din[CTL_EN_B];
        end
    end

    // Reset bits are strobes, not stored
    assign clr_a = ctl_wr && din[CTL_RST_A];
    assign clr_b = ctl_wr && din[CTL_RST_B];

    // Busy window, restarted by every data write
    always_ff @(posedge zero) begin
        if (rst) begin
            busy_cnt <= '0;
        end else if (data_wr) begin
            busy_cnt <= BUSY_W'(BUSY_CYCLES);
        end else if (busy) begin
            busy_cnt <= busy_cnt - 1'b1;
        end
    end

    assign busy = busy_cnt != '0;

    // Same status byte for every address
    assign dout = {busy, 5'd0, flag_b, flag_a};

endmodule

// ==== hw/opn_timebase.sv ====
// Chip timebase
// Divides the master clock into the internal clock enable and
// counts operator slots on it, giving one sample_tick per sample
`timescale 1ns/1ps

module opn_timebase import opn_pkg::*; (
    input  logic zero,
    input  logic rst,
    output logic sample_tick
);

    logic [PRE_W-1:0]  pre_cnt;
    logic [SLOT_W-1:0] slot_cnt;
    logic              clk_en;
    logic              slot_wrap;

    assign clk_en    = pre_cnt == PRE_W'(PRESCALE - 1);
    assign slot_wrap = slot_cnt == SLOT_W'(SLOTS - 1);

    // Prescaler, one enable every PRESCALE clocks
    always_ff @(posedge zero) begin
        if (rst) begin
            pre_cnt <= '0;
        end else if (clk_en) begin
            pre_cnt <= '0;
        end else begin
            pre_cnt <= pre_cnt + 1'b1;
        end
    end

    // Slot counter steps on the clock enable
    always_ff @(posedge zero) begin
        if (rst) begin
            slot_cnt <= '0;
        end else if (clk_en) begin
            if (slot_wrap) begin
                slot_cnt <= '0;
            end else begin
                slot_cnt <= slot_cnt + 1'b1;
            end
        end
    end

    // Registered so the first pulse lands SAMPLE_CYCLES after reset
    always_ff @(posedge zero) begin
        if (rst) begin
            sample_tick <= 1'b0;
        end else begin
            sample_tick <= clk_en && slot_wrap;
        end
    end

endmodule

// ==== hw/opn_top.sv ====
// OPN host interface top level
// CPU bus with address/data writes, busy window, chip timebase,
// timers A and B with their flags, status byte and IRQ output
`timescale 1ns/1ps

module opn_top import opn_pkg::*; (
    input  logic       zero,     // Master clock
    input  logic       rst,
    input  logic [7:0] din,
    input  logic [1:0] addr,
    input  logic       cs_n,
    input  logic       wr_n,
    output logic [7:0] dout,
    output logic       irq_n
);

    logic            sample_tick;
    logic [TA_W-1:0] value_a;
    logic [TB_W-1:0] value_b;
    logic            load_a, load_b;
    logic            en_a, en_b;
    logic            clr_a, clr_b;
    logic            flag_a, flag_b;

    opn_timebase u_timebase (
        .zero        ( zero        ),
        .rst         ( rst         ),
        .sample_tick ( sample_tick )
    );

    opn_regs u_regs (
        .zero    ( zero    ),
        .rst     ( rst     ),
        .din     ( din     ),
        .addr    ( addr    ),
        .cs_n    ( cs_n    ),
        .wr_n    ( wr_n    ),
        .flag_a  ( flag_a  ),
        .flag_b  ( flag_b  ),
        .value_a ( value_a ),
        .value_b ( value_b ),
        .load_a  ( load_a  ),
        .load_b  ( load_b  ),
        .en_a    ( en_a    ),
        .en_b    ( en_b    ),
        .clr_a   ( clr_a   ),
        .clr_b   ( clr_b   ),
        .dout    ( dout    )
    );

    opn_timers u_timers (
        .zero        ( zero        ),
        .rst         ( rst         ),
        .sample_tick ( sample_tick ),
        .value_a     ( value_a     ),
        .value_b     ( value_b     ),
        .load_a      ( load_a      ),
        .load_b      ( load_b      ),
        .en_a        ( en_a        ),
        .en_b        ( en_b        ),
        .clr_a       ( clr_a       ),
        .clr_b       ( clr_b       ),
        .flag_a      ( flag_a      ),
        .flag_b      ( flag_b      ),
        .irq_n       ( irq_n       )
    );

endmodule

// ==== test/opn_asserts.sv ====
// OPN control section checks
// A small bus model follows the register writes and times each timer
// from its start
// The properties hold the status byte and irq_n to the register map
// and the timer rules
`timescale 1ns/1ps

module opn_asserts import opn_pkg::*; (
    input logic       zero,
    input logic       rst,
    input logic [7:0] din,
    input logic [1:0] addr,
    input logic       cs_n,
    input logic       wr_n,
    input logic [7:0] dout,
    input logic       irq_n
);

    bit              failed = 1'b0;   // Sticky error bit
    logic            wr_addr, wr_data;
    logic            wr_p1, wr_p2, wr_ctl;
    logic [7:0]      lat;             // Register address as latched
    logic [TA_W-1:0] va;
    logic [TB_W-1:0] vb;
    logic            lda, ldb, ena, enb;
    logic            run_a, run_b;    // Started with the flag enabled
    logic [1:0]      prev_flags;
    int              t_a, t_b, since_wr;
    int              lo_a, hi_a, lo_b, hi_b;

    assign wr_addr = !cs_n && !wr_n && !addr[0];
    assign wr_data = !cs_n && !wr_n && addr[0];
    assign wr_p1   = wr_data && !addr[1];
    assign wr_p2   = wr_data && addr[1];
    assign wr_ctl  = wr_p1 && (lat == REG_TCTL);

    // Flag window in clocks from the cycle the load bit rises
    assign lo_a = (2**TA_W - int'(va) - 1) * SAMPLE_CYCLES;
    assign hi_a = (2**TA_W - int'(va) + 1) * SAMPLE_CYCLES;
    assign lo_b = (2**TB_W - int'(vb) - 1) * TB_DIV * SAMPLE_CYCLES;
    assign hi_b = (2**TB_W - int'(vb) + 1) * TB_DIV * SAMPLE_CYCLES;

    always_ff @(posedge zero) begin
        if (rst) begin
            lat        <= '0;
            va         <= '0;
            vb         <= '0;
            lda        <= 1'b0;
            ldb        <= 1'b0;
            ena        <= 1'b0;
            enb        <= 1'b0;
            run_a      <= 1'b0;
            run_b      <= 1'b0;
            t_a        <= 0;
            t_b        <= 0;
            since_wr   <= BUSY_CYCLES + 1;
            prev_flags <= 2'b00;
        end else begin
            t_a        <= t_a + 1;
            t_b        <= t_b + 1;
            prev_flags <= dout[1:0];
            if (wr_addr) begin
                lat <= din;
            end
            if (wr_data) begin
                since_wr <= 1;
            end else if (since_wr <= BUSY_CYCLES) begin
                since_wr <= since_wr + 1;
            end
            if (wr_p1) begin
                case (lat)
                    REG_TA_HI: va[TA_W-1:2] <= din;
                    REG_TA_LO: va[1:0]      <= din[1:0];
                    REG_TB:    vb           <= din;
                    default: ;
                endcase
            end
            if (dout[0]) begin
                run_a <= 1'b0;              // Flag seen closes the window
            end
            if (dout[1]) begin
                run_b <= 1'b0;
            end
            if (wr_ctl) begin
                lda <= din[CTL_LOAD_A];
                ldb <= din[CTL_LOAD_B];
                ena <= din[CTL_EN_A];
                enb <= din[CTL_EN_B];
                if (!lda && din[CTL_LOAD_A] && din[CTL_EN_A]) begin
                    run_a <= 1'b1;
                    t_a   <= 0;
                end
                if (!ldb && din[CTL_LOAD_B] && din[CTL_EN_B]) begin
                    run_b <= 1'b1;
                    t_b   <= 0;
                end
            end
        end
    end

    task automatic report_failure(input string name, input int expected, input int actual);
        $error("FAILED %s: expected %0d, actual %0d", name, expected, actual);
        failed = 1'b1;
    endtask

    reset_state: assert property (@(posedge zero) $fell(rst) |-> irq_n && dout == 8'h00)
        else report_failure("reset_state {irq_n,dout}", 256, int'({irq_n, dout}));

    // Busy window
    busy_on: assert property (@(posedge zero) disable iff (rst)
        (since_wr <= BUSY_CYCLES) |-> dout[7])
        else report_failure("busy_on", 1, int'(dout[7]));
    busy_off: assert property (@(posedge zero) disable iff (rst)
        (since_wr > BUSY_CYCLES) |-> !dout[7])
        else report_failure("busy_off", 0, int'(dout[7]));

    irq_match: assert property (@(posedge zero) disable iff (rst)
        irq_n == !(dout[0] || dout[1]))
        else report_failure("irq_match", int'(!(dout[0] || dout[1])), int'(irq_n));

    // Timer latency in clocks since the load bit rose
    timer_a_early: assert property (@(posedge zero) disable iff (rst)
        run_a && dout[0] |-> t_a >= lo_a)
        else report_failure("timer_a_early min cycles", lo_a, t_a);
    timer_a_late: assert property (@(posedge zero) disable iff (rst)
        run_a && !dout[0] |-> t_a < hi_a)
        else report_failure("timer_a_late max cycles", hi_a, t_a);
    timer_b_early: assert property (@(posedge zero) disable iff (rst)
        run_b && dout[1] |-> t_b >= lo_b)
        else report_failure("timer_b_early min cycles", lo_b, t_b);
    timer_b_late: assert property (@(posedge zero) disable iff (rst)
        run_b && !dout[1] |-> t_b < hi_b)
        else report_failure("timer_b_late max cycles", hi_b, t_b);

    // A flag only rises with its enable bit set
    flag_a_disabled: assert property (@(posedge zero) disable iff (rst)
        $rose(dout[0]) |-> $past(ena))
        else report_failure("flag_a_disabled", 0, 1);
    flag_b_disabled: assert property (@(posedge zero) disable iff (rst)
        $rose(dout[1]) |-> $past(enb))
        else report_failure("flag_b_disabled", 0, 1);

    clear_a: assert property (@(posedge zero) disable iff (rst)
        wr_ctl && din[CTL_RST_A] |=> !dout[0])
        else report_failure("clear_a", 0, int'(dout[0]));
    clear_b: assert property (@(posedge zero) disable iff (rst)
        wr_ctl && din[CTL_RST_B] |=> !dout[1])
        else report_failure("clear_b", 0, int'(dout[1]));

    part2_write: assert property (@(posedge zero) disable iff (rst)
        wr_p2 |=> dout[1:0] == prev_flags && irq_n == !(|prev_flags))
        else report_failure("part2_write {irq_n,flags}", int'({!(|prev_flags), prev_flags}),
                            int'({irq_n, dout[1:0]}));

endmodule

// ==== test/opn_tb.sv ====
// Testbench for the OPN control section
// Runs reset, busy, timer A and B, flag reset and part 2 writes over
// the CPU bus, the bound assertions in opn_asserts judge the results
`timescale 1ns/1ps

module opn_tb import opn_pkg::*; ();

    localparam int TIMEOUT = 30000;   // Timer B at 250 needs about 14000

    logic            zero;
    logic            rst;
    logic [7:0]      din;
    logic [1:0]      addr;
    logic            cs_n;
    logic            wr_n;
    logic [7:0]      dout;
    logic            irq_n;
    int              cycles = 0;
    logic [TA_W-1:0] va;
    logic [TB_W-1:0] vb;

    opn_top dut (
        .zero  ( zero  ),
        .rst   ( rst   ),
        .din   ( din   ),
        .addr  ( addr  ),
        .cs_n  ( cs_n  ),
        .wr_n  ( wr_n  ),
        .dout  ( dout  ),
        .irq_n ( irq_n )
    );

    bind opn_top opn_asserts u_asserts (.*);

    always #4 zero = ~zero;

    // Cycle limit and assertion monitor
    always @(posedge zero) begin
        cycles <= cycles + 1;
        if (dut.u_asserts.failed) begin
            $display("SIMULATION FAILED");
            $fatal(1, "An assertion in opn_asserts failed");
        end else if (cycles >= TIMEOUT) begin
            $display("Timeout: test sequence still running after %0d cycles", TIMEOUT);
            $display("SIMULATION FAILED");
            $fatal(1, "Run stopped by the cycle limit");
        end
    end

    task automatic next_cycle();
        @(posedge zero);
        #1;
    endtask

    task automatic wait_cycles(input int n);
        repeat (n) next_cycle();
    endtask

    // One write cycle on the bus, strobes released afterwards
    task automatic bus_cycle(input logic a0, input logic part2, input logic [7:0] d);
        addr = {part2, a0};
        din  = d;
        cs_n = 1'b0;
        wr_n = 1'b0;
        next_cycle();
        cs_n = 1'b1;
        wr_n = 1'b1;
    endtask

    task automatic write_addr(input logic [7:0] a, input logic part2);
        bus_cycle(1'b0, part2, a);
    endtask

    task automatic write_data(input logic [7:0] d, input logic part2);
        bus_cycle(1'b1, part2, d);
    endtask

    task automatic write_reg(input logic [7:0] a, input logic [7:0] d);
        write_addr(a, 1'b0);
        write_data(d, 1'b0);
    endtask

    // Polls one status bit, the cycle limit catches a flag that never comes
    task automatic wait_status(input int bit_pos);
        while (!dout[bit_pos]) begin
            next_cycle();
        end
    endtask

    initial begin
        void'($urandom(56));
        zero = 1'b0;
        rst  = 1'b1;
        din  = 8'h00;
        addr = 2'b00;
        cs_n = 1'b1;
        wr_n = 1'b1;
        va   = '0;
        vb   = '0;
        repeat (2) @(posedge zero);
        #1;
        rst = 1'b0;
        wait_cycles(4);

        // Busy window, address phase alone first
        write_addr(REG_TB, 1'b0);
        wait_cycles(4);
        write_data(8'h00, 1'b0);
        wait_cycles(BUSY_CYCLES + 4);
        write_data(8'h00, 1'b0);
        wait_cycles(BUSY_CYCLES / 2);
        write_data(8'h00, 1'b0);            // Restarts the window
        wait_cycles(BUSY_CYCLES + 4);

        // Timer A
        va = TA_W'($urandom_range(1022, 1018));
        write_reg(REG_TA_HI, va[TA_W-1:2]);
        write_reg(REG_TA_LO, {6'd0, va[1:0]});
        write_reg(REG_TCTL, 8'h05);         // Load and enable A
        wait_status(0);

        // Timer B with A left running
        vb = TB_W'($urandom_range(254, 250));
        write_reg(REG_TB, vb);
        write_reg(REG_TCTL, 8'h0F);
        wait_status(1);

        // Part 2 copy of 0x27 with both reset bits
        write_addr(REG_TCTL, 1'b1);
        write_data(8'h30, 1'b1);
        wait_cycles(2);

        // Flag reset, A then B
        write_reg(REG_TCTL, 8'h10);
        wait_cycles(2);
        write_reg(REG_TCTL, 8'h20);
        wait_cycles(2);

        // Timer A loaded with 1022 but its enable low, two periods and a bit
        write_reg(REG_TA_HI, 8'hFF);
        write_reg(REG_TA_LO, 8'h02);
        write_reg(REG_TCTL, 8'h01);
        wait_cycles(2 * 2 * SAMPLE_CYCLES + SAMPLE_CYCLES);
        write_reg(REG_TCTL, 8'h00);
        wait_cycles(4);

        if (dut.u_asserts.failed) begin
            $display("SIMULATION FAILED");
            $fatal(1, "An assertion in opn_asserts failed");
        end else begin
            $display("SIMULATION PASSED");
            $finish;
        end
    end

endmodule

// ==== all.f ====
common/opn_pkg.sv
hw/timers/opn_timer_cnt.sv
hw/timers/opn_timers.sv
hw/regs/opn_regs.sv
hw/opn_timebase.sv
hw/opn_top.sv
test/opn_asserts.sv
test/opn_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the OPN testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module opn_tb -f all.f -o opn_sim

# Error limit raised so the testbench monitor reports the failure itself
out=$(./obj_dir/opn_sim +verilator+error+limit+100 2>&1 || true)
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -q "SIMULATION PASSED"; then
    exit 0
fi
exit 1
